//--- logic/deparse_consts.svh
`ifndef DEPARSE_CONSTS_SVH
`define DEPARSE_CONSTS_SVH

// stream beat widths
`define AXIS_DATA_W 256
`define AXIS_USER_W 128

// header region held for rewrite
`define HDR_BEATS 2
`define HDR_BYTES 64

`define NUM_ACTIONS 5
`define NUM_CONT 8
`define TABLE_DEPTH 16

// action word layout with the valid flag in bit 0
`define ACT_OFS_LSB 6
`define ACT_OFS_W 7
`define ACT_LEN_LSB 4
`define ACT_IDX_LSB 1

`endif

//--- logic/deparse_stream_pkg.sv
`include "deparse_consts.svh"

package deparse_stream_pkg;

	typedef struct packed {
		logic [`AXIS_DATA_W-1:0] data;
		logic [`AXIS_DATA_W/8-1:0] keep;
		logic [`AXIS_USER_W-1:0] user;
		logic last;
	} axis_beat_t;

	// egress source select
	typedef enum logic [1:0] {
		SRC_BEAT0 = 2'd0,
		SRC_BEAT1 = 2'd1,
		SRC_PKT = 2'd2
	} egress_src_e;

endpackage

//--- logic/deparse_phv_pkg.sv
`include "deparse_consts.svh"

package deparse_phv_pkg;

	typedef enum logic [`ACT_OFS_LSB-`ACT_LEN_LSB-1:0] {
		LEN_NONE = 2'd0,
		LEN_2B = 2'd1,
		LEN_4B = 2'd2,
		LEN_6B = 2'd3
	} field_len_e;

	typedef struct packed {
		logic [15-`ACT_OFS_LSB-`ACT_OFS_W:0] rsvd;
		logic [`ACT_OFS_W-1:0] ofs;
		field_len_e len;
		logic [`ACT_LEN_LSB-`ACT_IDX_LSB-1:0] idx;
		logic valid;
	} action_t;

	// action 0 in the low bits
	typedef action_t [`NUM_ACTIONS-1:0] action_entry_t;

	typedef struct packed {
		logic [`NUM_CONT-1:0][47:0] c6;
		logic [`NUM_CONT-1:0][31:0] c4;
		logic [`NUM_CONT-1:0][15:0] c2;
		logic [31:0] meta;
	} phv_t;

	typedef struct packed {
		logic [47:0] value;
		field_len_e len;
		logic [`ACT_OFS_W-1:0] ofs;
		logic valid;
	} field_t;

	// byte count is twice the length code
	function automatic logic [2:0] len_bytes(field_len_e len);
		return {len, 1'b0};
	endfunction

endpackage

//--- logic/deparse_fsm.sv
module deparse_fsm (
	input logic clk,
	input logic aresetn,
	input logic pkt_empty,
	input logic phv_empty,
	input logic pkt_last,
	input logic free,
	output logic pkt_rd,
	output logic phv_rd,
	output logic cap_beat0,
	output logic cap_beat1,
	output logic tbl_rd,
	output logic apply,
	output logic load,
	output deparse_stream_pkg::egress_src_e src
);
	import deparse_stream_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		BUF_HDR_1,
		REFORM_HDR,
		FLUSH_0,
		FLUSH_1,
		FLUSH_PKT
	} state_e;

	state_e state;
	state_e state_nxt;
	// beat 0 closes the packet
	logic single;
	logic last_seen;

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			state <= IDLE;
			single <= 1'b0;
			last_seen <= 1'b0;
		end else begin
			state <= state_nxt;
			if (cap_beat0) begin
				single <= pkt_last;
				last_seen <= pkt_last;
			end
			if (cap_beat1)
				last_seen <= pkt_last;
		end
	end

	always_comb begin
		state_nxt = state;
		pkt_rd = 1'b0;
		phv_rd = 1'b0;
		cap_beat0 = 1'b0;
		cap_beat1 = 1'b0;
		tbl_rd = 1'b0;
		apply = 1'b0;
		load = 1'b0;
		src = SRC_PKT;
		case (state)
			IDLE: begin
				if (!pkt_empty && !phv_empty) begin
					cap_beat0 = 1'b1;
					pkt_rd = 1'b1;
					tbl_rd = 1'b1;
					state_nxt = pkt_last ? REFORM_HDR : BUF_HDR_1;
				end
			end
			BUF_HDR_1: begin
				if (!pkt_empty) begin
					cap_beat1 = 1'b1;
					pkt_rd = 1'b1;
					state_nxt = REFORM_HDR;
				end
			end
			// PHV leaves its FIFO once the table entry is out
			REFORM_HDR: begin
				apply = 1'b1;
				phv_rd = 1'b1;
				state_nxt = FLUSH_0;
			end
			FLUSH_0: begin
				src = SRC_BEAT0;
				if (free) begin
					load = 1'b1;
					state_nxt = single ? IDLE : FLUSH_1;
				end
			end
			FLUSH_1: begin
				src = SRC_BEAT1;
				if (free) begin
					load = 1'b1;
					state_nxt = last_seen ? IDLE : FLUSH_PKT;
				end
			end
			FLUSH_PKT: begin
				if (!pkt_empty && free) begin
					load = 1'b1;
					pkt_rd = 1'b1;
					if (pkt_last)
						state_nxt = IDLE;
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	assert property (@(posedge clk) disable iff (!aresetn) pkt_rd |-> !pkt_empty);

endmodule

//--- logic/action_table.sv
`include "deparse_consts.svh"

module action_table (
	input logic clk,
	input logic cfg_wr,
	input logic [3:0] cfg_addr,
	input deparse_phv_pkg::action_entry_t cfg_entry,
	input logic rd,
	input logic [3:0] rd_addr,
	output deparse_phv_pkg::action_entry_t entry
);
	import deparse_phv_pkg::*;

	action_entry_t mem [`TABLE_DEPTH];

	always_ff @(posedge clk) begin
		if (cfg_wr)
			mem[cfg_addr] <= cfg_entry;
	end

	// output holds between lookups
	always_ff @(posedge clk) begin
		if (rd)
			entry <= mem[rd_addr];
	end

endmodule

//--- logic/container_select.sv
`include "deparse_consts.svh"

module container_select (
	input deparse_phv_pkg::action_t act,
	input deparse_phv_pkg::phv_t phv_in,
	output deparse_phv_pkg::field_t field
);
	import deparse_phv_pkg::*;

	logic [`ACT_OFS_W:0] end_ofs;

	always_comb begin
		field.ofs = act.ofs;
		field.len = act.len;
		case (act.len)
			LEN_2B: field.value = {32'b0, phv_in.c2[act.idx]};
			LEN_4B: field.value = {16'b0, phv_in.c4[act.idx]};
			LEN_6B: field.value = phv_in.c6[act.idx];
			default: field.value = '0;
		endcase
		end_ofs = {1'b0, act.ofs} + {{(`ACT_OFS_W-2){1'b0}}, len_bytes(act.len)};
		// field must end inside the header region
		field.valid = act.valid && (act.len != LEN_NONE) && (end_ofs <= `HDR_BYTES);
	end

endmodule

//--- logic/hdr_buffer.sv
`include "deparse_consts.svh"

module hdr_buffer (
	input logic clk,
	input logic aresetn,
	input deparse_stream_pkg::axis_beat_t pkt,
	input deparse_phv_pkg::phv_t phv,
	input deparse_phv_pkg::action_entry_t entry,
	input logic cap_beat0,
	input logic cap_beat1,
	input logic apply,
	output deparse_stream_pkg::axis_beat_t beat0,
	output deparse_stream_pkg::axis_beat_t beat1,
	output logic [3:0] vlan_addr
);
	import deparse_phv_pkg::*;

	localparam int HDR_W = `HDR_BEATS * `AXIS_DATA_W;
	localparam int MAX_FIELD_BYTES = 6;

	phv_t phv_q;
	field_t fields [`NUM_ACTIONS];
	logic [HDR_W-1:0] hdr_next;
	logic phv_held;

	// lookup starts in the capture cycle
	assign vlan_addr = phv.meta[7:4];

	for (genvar a = 0; a < `NUM_ACTIONS; a++) begin : g_sel
		container_select sel_i (
			.act(entry[a]),
			.phv_in(phv_q),
			.field(fields[a])
		);
	end

	// later actions overwrite earlier ones
	always_comb begin
		hdr_next = {beat1.data, beat0.data};
		for (int a = 0; a < `NUM_ACTIONS; a++) begin
			for (int j = 0; j < MAX_FIELD_BYTES; j++) begin
				if (fields[a].valid && (j < len_bytes(fields[a].len)))
					hdr_next[8 * (fields[a].ofs + j) +: 8] = fields[a].value[8 * j +: 8];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cap_beat0) begin
			beat0 <= pkt;
			phv_q <= phv;
		end
		if (cap_beat1)
			beat1 <= pkt;
		if (apply) begin
			beat0.data <= hdr_next[0 +: `AXIS_DATA_W];
			beat1.data <= hdr_next[`AXIS_DATA_W +: `AXIS_DATA_W];
		end
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn)
			phv_held <= 1'b0;
		else if (cap_beat0)
			phv_held <= 1'b1;
		else if (apply)
			phv_held <= 1'b0;
	end

	// one rewrite per captured header
	assert property (@(posedge clk) disable iff (!aresetn) apply |-> phv_held);

endmodule

//--- logic/egress_reg.sv
module egress_reg (
	input logic clk,
	input logic aresetn,
	input logic load,
	input deparse_stream_pkg::egress_src_e src,
	input deparse_stream_pkg::axis_beat_t beat0,
	input deparse_stream_pkg::axis_beat_t beat1,
	input deparse_stream_pkg::axis_beat_t pkt,
	output deparse_stream_pkg::axis_beat_t out,
	output logic out_valid,
	input logic out_ready,
	output logic free
);
	import deparse_stream_pkg::*;

	axis_beat_t sel;

	always_comb begin
		case (src)
			SRC_BEAT0: sel = beat0;
			SRC_BEAT1: sel = beat1;
			default: sel = pkt;
		endcase
	end

	assign free = !out_valid || out_ready;

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn)
			out_valid <= 1'b0;
		else if (load)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (load)
			out <= sel;
	end

	assert property (@(posedge clk) disable iff (!aresetn)
		out_valid && !out_ready |=> out_valid && $stable(out));

endmodule

//--- logic/deparser_top.sv
module deparser_top (
	input logic clk,
	input logic aresetn,
	input deparse_stream_pkg::axis_beat_t pkt,
	input logic pkt_empty,
	output logic pkt_rd,
	input deparse_phv_pkg::phv_t phv,
	input logic phv_empty,
	output logic phv_rd,
	output deparse_stream_pkg::axis_beat_t out,
	output logic out_valid,
	input logic out_ready,
	input logic cfg_wr,
	input logic [3:0] cfg_addr,
	input deparse_phv_pkg::action_entry_t cfg_entry
);
	import deparse_stream_pkg::*;
	import deparse_phv_pkg::*;

	logic cap_beat0;
	logic cap_beat1;
	logic tbl_rd;
	logic apply;
	logic load;
	logic free;
	logic [3:0] vlan_addr;
	egress_src_e src;
	action_entry_t entry;
	axis_beat_t beat0;
	axis_beat_t beat1;

	deparse_fsm fsm_i (
		.clk(clk),
		.aresetn(aresetn),
		.pkt_empty(pkt_empty),
		.phv_empty(phv_empty),
		.pkt_last(pkt.last),
		.free(free),
		.pkt_rd(pkt_rd),
		.phv_rd(phv_rd),
		.cap_beat0(cap_beat0),
		.cap_beat1(cap_beat1),
		.tbl_rd(tbl_rd),
		.apply(apply),
		.load(load),
		.src(src)
	);

	action_table table_i (
		.clk(clk),
		.cfg_wr(cfg_wr),
		.cfg_addr(cfg_addr),
		.cfg_entry(cfg_entry),
		.rd(tbl_rd),
		.rd_addr(vlan_addr),
		.entry(entry)
	);

	hdr_buffer hdr_i (
		.clk(clk),
		.aresetn(aresetn),
		.pkt(pkt),
		.phv(phv),
		.entry(entry),
		.cap_beat0(cap_beat0),
		.cap_beat1(cap_beat1),
		.apply(apply),
		.beat0(beat0),
		.beat1(beat1),
		.vlan_addr(vlan_addr)
	);

	egress_reg egress_i (
		.clk(clk),
		.aresetn(aresetn),
		.load(load),
		.src(src),
		.beat0(beat0),
		.beat1(beat1),
		.pkt(pkt),
		.out(out),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.free(free)
	);

endmodule

//--- verification/tb_deparser.sv
`include "deparse_consts.svh"

module tb_deparser;
	timeunit 1ns;
	timeprecision 1ps;

	import deparse_stream_pkg::*;
	import deparse_phv_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 4;
	localparam int HDR_W = `HDR_BEATS * `AXIS_DATA_W;
	// 1 + 2 + 6 + 4 * 2 beats over all tests
	localparam int TOTAL_BEATS = 17;

	logic clk = 1'b0;
	logic aresetn;
	axis_beat_t pkt;
	logic pkt_empty;
	logic pkt_rd;
	phv_t phv;
	logic phv_empty;
	logic phv_rd;
	axis_beat_t out;
	logic out_valid;
	logic out_ready;
	logic cfg_wr;
	logic [3:0] cfg_addr;
	action_entry_t cfg_entry;

	axis_beat_t pkt_fifo [$];
	phv_t phv_fifo [$];
	axis_beat_t got_q [$];
	logic pkt_pop = 1'b0;
	logic phv_pop = 1'b0;
	logic rand_ready = 1'b0;
	logic [31:0] lfsr = 32'hd2550aa6;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;

	deparser_top dut_i (
		.clk(clk),
		.aresetn(aresetn),
		.pkt(pkt),
		.pkt_empty(pkt_empty),
		.pkt_rd(pkt_rd),
		.phv(phv),
		.phv_empty(phv_empty),
		.phv_rd(phv_rd),
		.out(out),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.cfg_wr(cfg_wr),
		.cfg_addr(cfg_addr),
		.cfg_entry(cfg_entry)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic rand_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		return b;
	endfunction

	function automatic logic [31:0] rand_word();
		logic [31:0] w;
		for (int i = 0; i < 32; i++)
			w[i] = rand_bit();
		return w;
	endfunction

	function automatic phv_t rand_phv(logic [11:0] vlan);
		logic [$bits(phv_t)-1:0] bits;
		phv_t p;
		for (int i = 0; i < $bits(phv_t) / 32; i++)
			bits[32 * i +: 32] = rand_word();
		p = bits;
		p.meta[11:0] = vlan;
		return p;
	endfunction

	function automatic action_t make_action(int ofs, field_len_e len, int idx);
		action_t act;
		act = '0;
		act.ofs = 7'(ofs);
		act.len = len;
		act.idx = 3'(idx);
		act.valid = 1'b1;
		return act;
	endfunction

	// header byte k at bits 8k, container byte j lands on ofs + j
	function automatic logic [HDR_W-1:0] rewrite_hdr(logic [HDR_W-1:0] hdr, phv_t p,
			action_entry_t e);
		logic [47:0] val;
		int nbytes;
		for (int a = 0; a < `NUM_ACTIONS; a++) begin
			nbytes = 2 * int'(e[a].len);
			case (e[a].len)
				LEN_2B: val = 48'(p.c2[e[a].idx]);
				LEN_4B: val = 48'(p.c4[e[a].idx]);
				default: val = p.c6[e[a].idx];
			endcase
			if (e[a].valid && nbytes > 0 && int'(e[a].ofs) + nbytes <= `HDR_BYTES) begin
				for (int j = 0; j < nbytes; j++)
					hdr[8 * (int'(e[a].ofs) + j) +: 8] = val[8 * j +: 8];
			end
		end
		return hdr;
	endfunction

	// outputs are stable mid-cycle, so pops and transfers are sampled here
	always @(negedge clk) begin
		pkt_pop = pkt_rd;
		phv_pop = phv_rd;
		if (out_valid && out_ready)
			got_q.push_back(out);
	end

	// first-word-fall-through FIFO models
	always @(posedge clk) begin
		if (pkt_pop && pkt_fifo.size() > 0)
			void'(pkt_fifo.pop_front());
		if (phv_pop && phv_fifo.size() > 0)
			void'(phv_fifo.pop_front());
		pkt <= (pkt_fifo.size() > 0) ? pkt_fifo[0] : '0;
		pkt_empty <= (pkt_fifo.size() == 0);
		phv <= (phv_fifo.size() > 0) ? phv_fifo[0] : '0;
		phv_empty <= (phv_fifo.size() == 0);
		out_ready <= rand_ready ? rand_bit() : 1'b1;
	end

	task automatic write_entry(logic [3:0] addr, action_entry_t e);
		@(posedge clk);
		cfg_wr <= 1'b1;
		cfg_addr <= addr;
		cfg_entry <= e;
		@(posedge clk);
		cfg_wr <= 1'b0;
	endtask

	task automatic report_test(string name, int errs0);
		tests_run++;
		if (errors == errs0) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d mismatches", name, errors - errs0);
		end
	endtask

	task automatic check_quiet(string phase);
		checks++;
		assert (!out_valid && !pkt_rd && !phv_rd) else begin
			$display("reset_quiet: output valid or a FIFO pop seen %s", phase);
			errors++;
		end
	endtask

	// e is the entry the DUT should find at vlan[7:4]
	task automatic run_packet(string name, int nbeats, logic [11:0] vlan, action_entry_t e);
		axis_beat_t beats [$];
		axis_beat_t b;
		phv_t p;
		logic [HDR_W-1:0] hdr;
		p = rand_phv(vlan);
		for (int i = 0; i < nbeats; i++) begin
			for (int w = 0; w < `AXIS_DATA_W / 32; w++)
				b.data[32 * w +: 32] = rand_word();
			b.keep = '1;
			b.user = `AXIS_USER_W'(i);
			b.last = (i == nbeats - 1);
			beats.push_back(b);
		end
		phv_fifo.push_back(p);
		foreach (beats[i])
			pkt_fifo.push_back(beats[i]);
		hdr = {(nbeats > 1) ? beats[1].data : '0, beats[0].data};
		hdr = rewrite_hdr(hdr, p, e);
		beats[0].data = hdr[0 +: `AXIS_DATA_W];
		if (nbeats > 1)
			beats[1].data = hdr[`AXIS_DATA_W +: `AXIS_DATA_W];
		while (got_q.size() < nbeats)
			@(posedge clk);
		for (int i = 0; i < nbeats; i++) begin
			checks++;
			assert (got_q[i] === beats[i]) else begin
				$display("FAIL %s beat %0d expected %h actual %h", name, i, beats[i], got_q[i]);
				errors++;
			end
		end
		got_q.delete();
	endtask

	task automatic reset_quiet();
		int errs0;
		errs0 = errors;
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_quiet("during reset");
		end
		@(posedge clk);
		aresetn <= 1'b1;
		repeat (4) begin
			@(negedge clk);
			check_quiet("after reset");
		end
		report_test("reset_quiet", errs0);
	endtask

	task automatic single_beat_passthrough();
		int errs0;
		action_entry_t e;
		errs0 = errors;
		e = '0;
		// fully described action with the valid flag clear
		e[0] = make_action(8, LEN_4B, 2);
		e[0].valid = 1'b0;
		write_entry(4'h1, e);
		run_packet("single_beat_passthrough", 1, 12'h215, e);
		report_test("single_beat_passthrough", errs0);
	endtask

	task automatic field_lengths_and_overlap();
		int errs0;
		action_entry_t e;
		errs0 = errors;
		e[0] = make_action(4, LEN_2B, 1);
		// bytes 30..33 cross into beat 1
		e[1] = make_action(30, LEN_4B, 2);
		e[2] = make_action(40, LEN_6B, 3);
		e[3] = make_action(42, LEN_4B, 5);
		// would reach byte 65
		e[4] = make_action(60, LEN_6B, 0);
		write_entry(4'hc, e);
		run_packet("field_lengths_and_overlap", 2, 12'h0c7, e);
		report_test("field_lengths_and_overlap", errs0);
	endtask

	task automatic long_packet_backpressure();
		int errs0;
		action_entry_t e;
		errs0 = errors;
		e = '0;
		e[2] = make_action(20, LEN_6B, 4);
		write_entry(4'h6, e);
		rand_ready = 1'b1;
		run_packet("long_packet_backpressure", 6, 12'h460, e);
		rand_ready = 1'b0;
		report_test("long_packet_backpressure", errs0);
	endtask

	task automatic vlan_entry_select();
		int errs0;
		action_entry_t ea;
		action_entry_t eb;
		action_entry_t ec;
		errs0 = errors;
		ea = '0;
		eb = '0;
		ec = '0;
		ea[0] = make_action(0, LEN_2B, 0);
		eb[1] = make_action(10, LEN_6B, 7);
		ec[4] = make_action(50, LEN_4B, 6);
		write_entry(4'h3, ea);
		write_entry(4'h9, eb);
		run_packet("vlan_entry_select", 2, 12'h835, ea);
		run_packet("vlan_entry_select", 2, 12'h193, eb);
		// low nibble differs only
		run_packet("vlan_entry_select", 2, 12'h83a, ea);
		write_entry(4'h3, ec);
		run_packet("vlan_entry_select", 2, 12'h835, ec);
		report_test("vlan_entry_select", errs0);
	endtask

	initial begin
		#(TOTAL_BEATS * 50 * CLK_PERIOD);
		$display("watchdog expired before all tests finished");
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		aresetn = 1'b0;
		pkt = '0;
		pkt_empty = 1'b1;
		phv = '0;
		phv_empty = 1'b1;
		out_ready = 1'b1;
		cfg_wr = 1'b0;
		cfg_addr = '0;
		cfg_entry = '0;
		reset_quiet();
		single_beat_passthrough();
		field_lengths_and_overlap();
		long_packet_backpressure();
		vlan_entry_select();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- list.f
+incdir+logic
logic/deparse_stream_pkg.sv
logic/deparse_phv_pkg.sv
logic/deparse_fsm.sv
logic/action_table.sv
logic/container_select.sv
logic/hdr_buffer.sv
logic/egress_reg.sv
logic/deparser_top.sv
verification/tb_deparser.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tb_deparser
FILELIST = list.f
BUILD = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); test $$status -eq 0
	! grep -q "TEST FAILED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
